// File: sim/readout_cases.txt
// columns: step code, a, b (hex). 1 hit on channel a, b idle; 2 hit on a, random idle 0..b
// 3 read b words; 4 pause b cycles; 5 end test, lost_count a, fill_level b; f end of file
// reset state
5 0 0
// single hit
1 3 0
4 0 5
3 0 1
4 0 4
5 0 0
// burst, read after it ends
1 1 0
1 2 0
1 4 0
1 8 0
1 10 0
4 0 8
3 0 5
4 0 4
5 0 0
// overflow, 12 hits with no reads
1 0 0
1 1 0
1 2 0
1 3 0
1 4 0
1 5 0
1 6 0
1 7 0
1 8 0
1 9 0
1 a 0
1 b 0
4 0 8
5 4 7
// drain the 8 kept words
3 0 8
4 0 4
5 4 0
// hits and reads with random gaps
2 14 3
2 15 3
3 0 1
2 16 3
3 0 1
2 17 3
2 18 3
3 0 2
3 0 1
4 0 6
5 4 0
// refill to the limit across the pointer wrap
1 10 1
1 11 1
1 12 1
1 13 1
1 14 1
1 15 1
1 16 1
1 17 1
4 0 8
5 4 7
// drain, then refill again
3 0 8
1 1c 2
1 1d 2
1 1e 2
4 0 6
3 0 3
4 0 4
5 4 0
f 0 0

// File: src.f
logic/readout_pkg.sv
logic/hit_capture.sv
logic/hit_fifo.sv
logic/readout_formatter.sv
logic/hit_readout.sv
sim/readout_checker.sv
sim/hit_readout_tb.sv

// File: Makefile
# Verilator build and run for the hit readout path.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
TOP       ?= hit_readout_tb
RTL_TOP   ?= hit_readout
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/hit_readout_tb.sv
/*
 * Testbench for the hit readout path. Reads the test steps from the case
 * file, drives hits and host reads on the falling clock edge and prints the
 * closing counts. readout_checker watches the DUT and does the comparing.
 */

`timescale 1ns/1ps
`default_nettype none

module hit_readout_tb;

    import readout_pkg::*;

    localparam int step_words   = 256;  // three words per step.
    localparam int read_timeout = 50;   // cycles to wait for word_valid.

    logic                     clk;
    logic                     reset;
    logic                     hit;
    logic [channel_width-1:0] hit_channel;
    logic                     host_read;
    logic                     word_valid;
    logic [word_width-1:0]    word;
    logic [lost_width-1:0]    lost_count;
    logic [level_width-1:0]   fill_level;

    logic                     test_end;  // one-cycle strobe to the checker.
    logic [lost_width-1:0]    exp_lost;
    logic [level_width-1:0]   exp_level;
    int                       tests_run;
    int                       tests_failed;
    int                       errors_total;

    logic [15:0] steps [step_words];
    logic [7:0]  ptr;
    logic [15:0] code;
    logic        timed_out;
    logic        bad_step;
    logic        done;
    int          seed;

    hit_readout hit_readout_i (
        .clk         (clk),
        .reset       (reset),
        .hit         (hit),
        .hit_channel (hit_channel),
        .host_read   (host_read),
        .word_valid  (word_valid),
        .word        (word),
        .lost_count  (lost_count),
        .fill_level  (fill_level)
    );

    readout_checker readout_checker_i (
        .clk          (clk),
        .reset        (reset),
        .hit          (hit),
        .hit_channel  (hit_channel),
        .host_read    (host_read),
        .word_valid   (word_valid),
        .word         (word),
        .lost_count   (lost_count),
        .fill_level   (fill_level),
        .test_end     (test_end),
        .exp_lost     (exp_lost),
        .exp_level    (exp_level),
        .tests_run    (tests_run),
        .tests_failed (tests_failed),
        .errors_total (errors_total)
    );

    always #5 clk = ~clk;  // 10 ns period.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus steps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_hit(input logic [channel_width-1:0] channel, input int idle);
        hit         = 1'b1;
        hit_channel = channel;
        @(negedge clk);
        hit = 1'b0;
        repeat (idle) @(negedge clk);
    endtask

    task automatic random_hit(input logic [channel_width-1:0] channel, input int max_gap);
        int gap;
        gap = $unsigned($random(seed)) % (max_gap + 1);
        drive_hit(channel, gap);
    endtask

    // each read waits for a held word, then strobes host_read once.
    task automatic read_words(input int count);
        int i;
        int wait_cycles;
        for (i = 0; i < count && !timed_out; i++) begin
            wait_cycles = 0;
            while (!word_valid && wait_cycles < read_timeout) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (word_valid) begin
                host_read = 1'b1;
                @(negedge clk);
                host_read = 1'b0;
            end else begin
                timed_out = 1'b1;
                $display("ERROR: word_valid did not rise within %0d cycles", read_timeout);
            end
        end
    endtask

    task automatic end_test(input logic [lost_width-1:0] lost,
                            input logic [level_width-1:0] level);
        exp_lost  = lost;
        exp_level = level;
        test_end  = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        hit         = 1'b0;
        hit_channel = '0;
        host_read   = 1'b0;
        test_end    = 1'b0;
        exp_lost    = '0;
        exp_level   = '0;
        seed        = 55092;
        timed_out   = 1'b0;
        bad_step    = 1'b0;
        done        = 1'b0;
        ptr         = '0;
        $readmemh("sim/readout_cases.txt", steps);

        repeat (4) @(negedge clk);
        reset = 1'b0;

        while (!done && !timed_out && !bad_step && ptr < 8'd252) begin
            code = steps[ptr];
            case (code)
                16'h1: drive_hit(steps[ptr + 8'd1][channel_width-1:0], int'(steps[ptr + 8'd2]));
                16'h2: random_hit(steps[ptr + 8'd1][channel_width-1:0], int'(steps[ptr + 8'd2]));
                16'h3: read_words(int'(steps[ptr + 8'd2]));
                16'h4: repeat (int'(steps[ptr + 8'd2])) @(negedge clk);
                16'h5: end_test(steps[ptr + 8'd1][lost_width-1:0],
                                steps[ptr + 8'd2][level_width-1:0]);
                16'hf: done = 1'b1;
                default: begin
                    bad_step = 1'b1;
                    $display("ERROR: unknown step code %h in the case file", code);
                end
            endcase
            ptr = ptr + 8'd3;
        end

        if (!done && !timed_out && !bad_step) begin
            bad_step = 1'b1;
            $display("ERROR: the case file has no end marker");
        end

        @(negedge clk);  // one more edge of checking after the last step.
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && errors_total == 0 && tests_run > 0 &&
            !timed_out && !bad_step) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : hit_readout_tb

`default_nettype wire

// File: sim/readout_checker.sv
/*
 * Monitor for the hit readout path. Stamps every hit with its own cycle
 * count, keeps the words the DUT should hold (8 at most) and the hits it
 * should lose, checks each host read and closes each test on test_end.
 */

`timescale 1ns/1ps
`default_nettype none

module readout_checker (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  hit,
    input  logic [readout_pkg::channel_width-1:0] hit_channel,
    input  logic                                  host_read,
    input  logic                                  word_valid,
    input  logic [readout_pkg::word_width-1:0]    word,
    input  logic [readout_pkg::lost_width-1:0]    lost_count,
    input  logic [readout_pkg::level_width-1:0]   fill_level,
    input  logic                                  test_end,
    input  logic [readout_pkg::lost_width-1:0]    exp_lost,
    input  logic [readout_pkg::level_width-1:0]   exp_level,
    output int                                    tests_run,
    output int                                    tests_failed,
    output int                                    errors_total
);

    import readout_pkg::*;

    localparam int         capacity = 8;         // 7 in the FIFO, 1 in the output word.
    localparam logic [4:0] marker   = 5'b10101;

    hit_record_t                model_q [$];  // accepted, not yet read.
    hit_record_t                pend_rec;     // hit of the previous cycle.
    hit_record_t                rec;
    logic                       pend_valid;
    logic [timestamp_width-1:0] cycle;
    logic [lost_width-1:0]      model_lost;
    logic [31:0]                expected;
    int                         held;
    int                         test_errors;

    // marker, channel, six zero bits, timestamp.
    function automatic logic [31:0] expected_word(input hit_record_t r);
        return {marker, r.channel, 6'b000000, r.timestamp};
    endfunction

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("FAIL %s: got 0x%08h, expected 0x%08h (test %0d)",
                 name, got, want, tests_run + 1);
        test_errors++;
        errors_total++;
    endtask

    task automatic other_error(input string what);
        $display("ERROR in test %0d: %s", tests_run + 1, what);
        test_errors++;
        errors_total++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            model_q.delete();
            pend_valid   = 1'b0;
            cycle        = '0;
            model_lost   = '0;
            test_errors  = 0;
            tests_run    = 0;
            tests_failed = 0;
            errors_total = 0;
        end else begin
            held = model_q.size();
            if (word_valid && held == 0) begin
                value_mismatch("word_valid", 32'(word_valid), 32'h0);
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // host reads and stored hits
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (host_read) begin
                if (held == 0) begin
                    other_error("host read with no word expected");
                end else begin
                    rec      = model_q.pop_front();
                    expected = expected_word(rec);
                    if (word !== expected) value_mismatch("word", word, expected);
                end
            end

            // a hit is stored or lost one cycle after its strobe.
            if (pend_valid) begin
                if (held >= capacity) begin
                    if (model_lost != '1) model_lost = model_lost + lost_width'(1);
                end else begin
                    model_q.push_back(pend_rec);
                end
            end
            pend_valid         = hit;
            pend_rec.channel   = hit_channel;
            pend_rec.timestamp = cycle;
            cycle              = cycle + timestamp_width'(1);

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // end of test
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (test_end) begin
                if (lost_count !== exp_lost) begin
                    value_mismatch("lost_count", 32'(lost_count), 32'(exp_lost));
                end
                if (lost_count !== model_lost) begin
                    value_mismatch("lost_count (model)", 32'(lost_count), 32'(model_lost));
                end
                if (fill_level !== exp_level) begin
                    value_mismatch("fill_level", 32'(fill_level), 32'(exp_level));
                end
                tests_run = tests_run + 1;
                if (test_errors == 0) begin
                    $display("test %0d passed", tests_run);
                end else begin
                    $display("test %0d failed with %0d errors", tests_run, test_errors);
                    tests_failed = tests_failed + 1;
                end
                test_errors = 0;
            end
        end
    end

endmodule : readout_checker

`default_nettype wire

// File: logic/hit_readout.sv
/*
 * Top level of the hit readout path. Connects the capture side, the
 * record FIFO and the output formatter. All logic runs on clk.
 */

`timescale 1ns/1ps
`default_nettype none

module hit_readout (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  hit,
    input  logic [readout_pkg::channel_width-1:0] hit_channel,
    input  logic                                  host_read,
    output logic                                  word_valid,
    output logic [readout_pkg::word_width-1:0]    word,
    output logic [readout_pkg::lost_width-1:0]    lost_count,
    output logic [readout_pkg::level_width-1:0]   fill_level
);

    import readout_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal connections
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic        push;
    hit_record_t push_record;
    logic        full;
    logic        empty;
    hit_record_t head_record;  // valid while empty is low.
    logic        pop;

    hit_capture hit_capture_i (
        .clk         (clk),
        .reset       (reset),
        .hit         (hit),
        .hit_channel (hit_channel),
        .full        (full),
        .push        (push),
        .push_record (push_record),
        .lost_count  (lost_count)
    );

    hit_fifo #(
        .data_width ($bits(hit_record_t)),
        .depth      (fifo_depth)
    ) hit_fifo_i (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_data  (push_record),
        .pop        (pop),
        .full       (full),
        .empty      (empty),
        .head_data  (head_record),
        .fill_level (fill_level)
    );

    readout_formatter readout_formatter_i (
        .clk         (clk),
        .reset       (reset),
        .empty       (empty),
        .head_record (head_record),
        .host_read   (host_read),
        .pop         (pop),
        .word_valid  (word_valid),
        .word        (word)
    );

endmodule : hit_readout

`default_nettype wire

// File: logic/readout_formatter.sv
/*
 * Output side of the readout path. Moves records from the FIFO head into
 * a one-word output register and formats them as 32-bit data words. The
 * host takes a word with a single-cycle read strobe while word_valid is
 * high.
 */

`timescale 1ns/1ps
`default_nettype none

module readout_formatter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               empty,
    input  readout_pkg::hit_record_t           head_record,
    input  logic                               host_read,
    output logic                               pop,
    output logic                               word_valid,
    output logic [readout_pkg::word_width-1:0] word
);

    import readout_pkg::*;

    logic                  slot_free;  // output register free after this cycle.
    logic [word_width-1:0] next_word;  // head record in host format.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pop decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The register can take a new word when it holds nothing, or when
    // the host takes the current word in this same cycle.
    assign slot_free = !word_valid || host_read;
    assign pop       = slot_free && !empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // word format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign next_word = {
        hit_marker,               // fixed marker on top.
        head_record.channel,
        {pad_width{1'b0}},        // unused bits read as zero.
        head_record.timestamp
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            word_valid <= 1'b0;
        end else if (pop) begin
            word_valid <= 1'b1;  // popped record lands next edge.
        end else if (host_read) begin
            word_valid <= 1'b0;  // read with nothing behind it.
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            word <= next_word;
        end
    end

endmodule : readout_formatter

`default_nettype wire

// File: logic/hit_fifo.sv
/*
 * Circular FIFO with wrapping read and write pointers. Full is decoded
 * from the pointers, empty is registered with a look-ahead on pop, and
 * the head word is read registered from the next read address. One slot
 * is always left free, so depth-1 words fit.
 */

`timescale 1ns/1ps
`default_nettype none

module hit_fifo #(
    parameter int data_width = 21,
    parameter int depth      = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 push,
    input  logic [data_width-1:0]                push_data,
    input  logic                                 pop,
    output logic                                 full,
    output logic                                 empty,
    output logic [data_width-1:0]                head_data,
    output logic [readout_pkg::level_width-1:0]  fill_level
);

    import readout_pkg::*;

    localparam int ptr_width = $clog2(depth);

    logic [data_width-1:0] mem [depth];

    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_next;    // read pointer one step on.
    logic [ptr_width-1:0] rd_addr;    // address the head is read from.
    logic                 empty_loc;  // pointer compare, not registered.
    logic [ptr_width:0]   level;      // one bit wider for the wrap case.

    // step a pointer, wrapping after the last slot.
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        logic [ptr_width-1:0] result;
        if (ptr == ptr_width'(depth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rd_next   = next_ptr(rd_ptr);
    assign rd_addr   = pop ? rd_next : rd_ptr;
    assign empty_loc = (wr_ptr == rd_ptr);
    assign full      = (next_ptr(wr_ptr) == rd_ptr);  // one slot kept free.

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop && !empty_loc) begin
            rd_ptr <= rd_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (push && !full) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
    end

    // look ahead on pop so empty rises together with the new head.
    // A write in the same cycle shows up one cycle later.
    always_ff @(posedge clk) begin
        if (reset) begin
            empty <= 1'b1;
        end else if (pop && !empty_loc) begin
            empty <= (wr_ptr == rd_next);
        end else begin
            empty <= empty_loc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        head_data <= mem[rd_addr];  // falls through one cycle after write or pop.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill level
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            level = {1'b0, wr_ptr} - {1'b0, rd_ptr};
        end else begin
            level = {1'b0, wr_ptr} + (ptr_width + 1)'(depth) - {1'b0, rd_ptr};
        end
    end

    assign fill_level = level_width'(level);

endmodule : hit_fifo

`default_nettype wire

// File: logic/hit_capture.sv
/*
 * Input side of the readout path. Stamps each front-end hit strobe with
 * the free-running cycle counter and hands the record to the FIFO one
 * cycle later. Hits that find the FIFO full are counted as lost.
 */

`timescale 1ns/1ps
`default_nettype none

module hit_capture (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                hit,
    input  logic [readout_pkg::channel_width-1:0] hit_channel,
    input  logic                                full,
    output logic                                push,
    output readout_pkg::hit_record_t            push_record,
    output logic [readout_pkg::lost_width-1:0]  lost_count
);

    import readout_pkg::*;

    logic [timestamp_width-1:0] timestamp;  // free-running cycle count.
    logic                       pending;    // stamped hit waiting for the FIFO.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cycle counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // zero in the first cycle after reset, wraps at 16 bits.
    always_ff @(posedge clk) begin
        if (reset) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hit register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            pending <= hit;  // one-cycle strobe in, one-cycle strobe out.
        end
    end

    // record payload, stamped with the count of the hit cycle.
    always_ff @(posedge clk) begin
        if (hit) begin
            push_record.channel   <= hit_channel;
            push_record.timestamp <= timestamp;
        end
    end

    // The full flag is sampled in the cycle the record is offered, so it
    // already reflects every earlier write and pop. A record offered to a
    // full FIFO is dropped here rather than silently ignored by the FIFO.
    assign push = pending && !full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lost hits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            lost_count <= '0;
        end else if (pending && full) begin
            if (lost_count != {lost_width{1'b1}}) begin
                lost_count <= lost_count + 1'b1;  // saturates at all ones.
            end
        end
    end

endmodule : hit_capture

`default_nettype wire

// File: logic/readout_pkg.sv
/*
 * Shared widths, sizes and the hit record type for the hit readout path.
 * Imported by the capture, FIFO, formatter and top level modules.
 */

`default_nettype none

package readout_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // front end and timestamp
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int channel_width   = 5;   // front-end channel number.
    localparam int timestamp_width = 16;  // free-running cycle counter.
    localparam int lost_width      = 16;  // saturating lost-hit counter.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FIFO sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one slot always stays free, so 7 records fit.
    localparam int fifo_depth  = 8;
    localparam int level_width = $clog2(fifo_depth);  // fill level, 3 bits.

    // one stamped hit as it passes through the FIFO.
    typedef struct packed {
        logic [channel_width-1:0]   channel;
        logic [timestamp_width-1:0] timestamp;
    } hit_record_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host data word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // layout: marker [31:27], channel [26:22], zero [21:16], stamp [15:0]
    localparam int word_width   = 32;
    localparam int marker_width = 5;
    localparam logic [marker_width-1:0] hit_marker = 5'b10101;  // top of every word.

    // zero bits between the channel and the timestamp.
    localparam int pad_width = word_width - marker_width - channel_width
                               - timestamp_width;

endpackage : readout_pkg

`default_nettype wire
